// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal
TOP       ?= tb_lfo_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== project.f ====
src/lfo_pkg.sv
src/lfo_regs_ctrl.sv
src/lfo_phase_acc.sv
src/lfo_noise_lfsr.sv
src/lfo_wave_shaper.sv
src/lfo_top.sv
testbench/tb_lfo_top.sv

// ==== src/lfo_noise_lfsr.sv ====
// LFO noise source, 15-bit two-tap LFSR stepped once per sample
`timescale 1ns/1ps

module lfo_noise_lfsr (
    input  logic        clk,
    input  logic        rst,
    input  logic        tick,
    output logic [14:0] noise
);

    logic feedback;

    // taps on the two lowest bits, maximal length
    assign feedback = noise[0] ^ noise[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            noise <= lfo_pkg::LFSR_SEED;
        end else if (tick) begin
            noise <= {feedback, noise[14:1]};
        end
    end

endmodule

// ==== src/lfo_phase_acc.sv ====
// LFO phase accumulator
// maps the frequency byte to an increment and advances phase per tick
`timescale 1ns/1ps

module lfo_phase_acc (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tick,
    input  logic                        phase_clear,
    input  logic [7:0]                  freq,
    output logic [lfo_pkg::PHASE_W-1:0] phase
);

    logic [3:0]                  exponent;
    logic [3:0]                  mantissa;
    logic [19:0]                 scaled;
    logic [lfo_pkg::PHASE_W-1:0] phase_inc;

    assign exponent = freq[7:4];
    assign mantissa = freq[3:0];

    // implicit leading one, max 31 << 15 still fits in 20 bits
    assign scaled    = {15'd0, 1'b1, mantissa} << exponent;
    assign phase_inc = scaled[19:4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
        end else if (phase_clear) begin
            phase <= '0;
        end else if (tick) begin
            // wraps modulo 2^16
            phase <= phase + phase_inc;
        end
    end

endmodule

// ==== src/lfo_pkg.sv ====
// LFO shared definitions
// waveform and register enums, bus structs and datapath constants
package lfo_pkg;

    // phase accumulator width
    localparam int PHASE_W = 16;

    // noise register value after reset
    localparam logic [14:0] LFSR_SEED = 15'h7fff;

    // waveform select, as written to the wave register
    typedef enum logic [1:0] {
        WAVE_SAW      = 2'd0,
        WAVE_SQUARE   = 2'd1,
        WAVE_TRIANGLE = 2'd2,
        WAVE_NOISE    = 2'd3
    } lfo_wave_e;

    // host register map
    typedef enum logic [1:0] {
        REG_CTRL  = 2'd0,
        REG_FREQ  = 2'd1,
        REG_DEPTH = 2'd2,
        REG_WAVE  = 2'd3
    } reg_addr_e;

    // one host register write
    typedef struct packed {
        reg_addr_e   addr;
        logic [7:0]  data;
    } reg_write_t;

    // live LFO configuration
    typedef struct packed {
        logic [7:0]  freq;
        logic [6:0]  amd;
        logic [6:0]  pmd;
        lfo_wave_e   wave;
    } lfo_cfg_t;

    // modulation outputs, am unsigned and pm two's complement
    typedef struct packed {
        logic [7:0]         am;
        logic signed [7:0]  pm;
    } lfo_out_t;

endpackage

// ==== src/lfo_regs_ctrl.sv ====
// LFO register file and sample timing
// decodes host writes, runs the sample divider, issues phase clears
`timescale 1ns/1ps

module lfo_regs_ctrl #(
    parameter int SAMPLE_DIV = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_strobe,
    input  lfo_pkg::reg_write_t  wr,
    output lfo_pkg::lfo_cfg_t    cfg,
    output logic                 tick,
    output logic                 phase_clear
);

    localparam int CNT_W = $clog2(SAMPLE_DIV);

    logic [CNT_W-1:0] div_cnt;
    logic             div_hit;
    logic             tick_pend;
    logic             tick_due;

    // free running sample divider
    assign div_hit = (div_cnt == CNT_W'(SAMPLE_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else if (div_hit) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // a tick that lands on a clear slips by one cycle
    assign tick_due = div_hit || tick_pend;
    assign tick     = tick_due && !phase_clear;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_pend <= 1'b0;
        end else begin
            tick_pend <= tick_due && phase_clear;
        end
    end

    // register writes, visible one cycle after the strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg         <= '0;
            phase_clear <= 1'b0;
        end else begin
            phase_clear <= 1'b0;
            if (wr_strobe) begin
                case (wr.addr)
                    lfo_pkg::REG_CTRL: begin
                        phase_clear <= wr.data[0];
                    end
                    lfo_pkg::REG_FREQ: begin
                        cfg.freq <= wr.data;
                    end
                    lfo_pkg::REG_DEPTH: begin
                        // bit 7 picks pm depth over am depth
                        if (wr.data[7]) begin
                            cfg.pmd <= wr.data[6:0];
                        end else begin
                            cfg.amd <= wr.data[6:0];
                        end
                    end
                    lfo_pkg::REG_WAVE: begin
                        cfg.wave <= lfo_pkg::lfo_wave_e'(wr.data[1:0]);
                    end
                endcase
            end
        end
    end

endmodule

// ==== src/lfo_top.sv ====
// LFO top level
// register control, phase, noise and shaper blocks wired together
`timescale 1ns/1ps

module lfo_top #(
    parameter int SAMPLE_DIV = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_strobe,
    input  lfo_pkg::reg_write_t  wr,
    output lfo_pkg::lfo_out_t    out,
    output logic                 out_valid
);

    lfo_pkg::lfo_cfg_t           cfg;
    logic                        tick;
    logic                        phase_clear;
    logic [lfo_pkg::PHASE_W-1:0] phase;
    logic [14:0]                 noise;

    lfo_regs_ctrl #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .wr_strobe   (wr_strobe),
        .wr          (wr),
        .cfg         (cfg),
        .tick        (tick),
        .phase_clear (phase_clear)
    );

    lfo_phase_acc u_phase (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .phase_clear (phase_clear),
        .freq        (cfg.freq),
        .phase       (phase)
    );

    // noise keeps running through phase clears
    lfo_noise_lfsr u_noise (
        .clk   (clk),
        .rst   (rst),
        .tick  (tick),
        .noise (noise)
    );

    lfo_wave_shaper u_shaper (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .cfg       (cfg),
        .phase     (phase),
        .noise     (noise),
        .out       (out),
        .out_valid (out_valid)
    );

endmodule

// ==== src/lfo_wave_shaper.sv ====
// LFO wave shaper
// picks the waveform, scales it by AM and PM depth, registers the result
`timescale 1ns/1ps

module lfo_wave_shaper (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        tick,
    input  lfo_pkg::lfo_cfg_t           cfg,
    input  logic [lfo_pkg::PHASE_W-1:0] phase,
    input  logic [14:0]                 noise,
    output lfo_pkg::lfo_out_t           out,
    output logic                        out_valid
);

    logic               tick_d;
    logic [7:0]         wave_u;
    logic [6:0]         wave_t;
    logic [7:0]         w;
    logic [14:0]        am_prod;
    logic signed [8:0]  centered;
    logic signed [16:0] pm_prod;
    logic signed [16:0] pm_shift;

    // phase and noise are fresh one cycle after tick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_d <= 1'b0;
        end else begin
            tick_d <= tick;
        end
    end

    assign wave_u = phase[lfo_pkg::PHASE_W-1 -: 8];
    assign wave_t = phase[lfo_pkg::PHASE_W-2 -: 7];

    always_comb begin
        w = wave_u;
        case (cfg.wave)
            lfo_pkg::WAVE_SAW: begin
                w = wave_u;
            end
            lfo_pkg::WAVE_SQUARE: begin
                w = phase[lfo_pkg::PHASE_W-1] ? 8'd0 : 8'd255;
            end
            lfo_pkg::WAVE_TRIANGLE: begin
                // rising half then mirrored falling half
                w = phase[lfo_pkg::PHASE_W-1] ? ~{wave_t, 1'b0} : {wave_t, 1'b0};
            end
            lfo_pkg::WAVE_NOISE: begin
                w = noise[7:0];
            end
            default: begin
                w = wave_u;
            end
        endcase
    end

    // am depth, unsigned
    assign am_prod = w * cfg.amd;

    // pm depth, centred on zero
    assign centered = $signed({1'b0, w}) - 9'sd128;
    assign pm_prod  = centered * $signed({1'b0, cfg.pmd});
    assign pm_shift = pm_prod >>> 7;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= tick_d;
            if (tick_d) begin
                out.am <= am_prod[14:7];
                out.pm <= pm_shift[7:0];
            end
        end
    end

endmodule

// ==== testbench/tb_lfo_top.sv ====
// LFO testbench
// table-driven register writes, every output checked against a reference model
`timescale 1ns/1ps

module tb_lfo_top;

    localparam int SAMPLE_DIV = 16;
    localparam int MAX_STEPS  = 24;
    localparam int WAIT_LIMIT = 4 * SAMPLE_DIV;

    logic                clk;
    logic                rst;
    logic                wr_strobe;
    lfo_pkg::reg_write_t wr;
    lfo_pkg::lfo_out_t   out;
    logic                out_valid;

    // stimulus table, one row per step
    string               step_name [MAX_STEPS];
    lfo_pkg::reg_write_t step_wr   [MAX_STEPS][4];
    int                  step_nwr  [MAX_STEPS];
    int                  step_nout [MAX_STEPS];
    int                  num_steps;

    // reference model state
    logic [lfo_pkg::PHASE_W-1:0] m_phase;
    logic [14:0]                 m_lfsr;
    logic [7:0]                  m_freq;
    logic [6:0]                  m_amd;
    logic [6:0]                  m_pmd;
    lfo_pkg::lfo_wave_e          m_wave;

    lfo_top #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_lfo_top (
        .clk       (clk),
        .rst       (rst),
        .wr_strobe (wr_strobe),
        .wr        (wr),
        .out       (out),
        .out_valid (out_valid)
    );

    always #20 clk = ~clk;

    task automatic add_step(input string name, input int nout);
        step_name[num_steps] = name;
        step_nout[num_steps] = nout;
        step_nwr[num_steps]  = 0;
        num_steps++;
    endtask

    task automatic add_write(input lfo_pkg::reg_addr_e addr, input logic [7:0] data);
        int s;
        s = num_steps - 1;
        step_wr[s][step_nwr[s]].addr = addr;
        step_wr[s][step_nwr[s]].data = data;
        step_nwr[s]++;
    endtask

    task automatic fail_run(input string why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic compare_out(input string name, input lfo_pkg::lfo_out_t exp_v,
                               input lfo_pkg::lfo_out_t act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected am=%0d pm=%0d actual am=%0d pm=%0d",
                     name, exp_v.am, exp_v.pm, act_v.am, act_v.pm);
            fail_run("output mismatch");
        end
    endtask

    task automatic compare_valid(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("Error: %s expected out_valid=%0b actual out_valid=%0b",
                     name, exp_v, act_v);
            fail_run("out_valid mismatch");
        end
    endtask

    // increment from exponent and mantissa of the frequency byte
    function automatic logic [15:0] phase_inc(input logic [7:0] freq);
        int scaled;
        scaled = (16 + int'(freq[3:0])) << freq[7:4];
        scaled = scaled >> 4;
        return scaled[15:0];
    endfunction

    function automatic logic [14:0] lfsr_next(input logic [14:0] s);
        return {s[0] ^ s[1], s[14:1]};
    endfunction

    function automatic lfo_pkg::lfo_out_t model_out();
        lfo_pkg::lfo_out_t res;
        int w;
        int t;
        int am;
        int pm;
        t = int'(m_phase[14:8]);
        case (m_wave)
            lfo_pkg::WAVE_SAW:      w = int'(m_phase[15:8]);
            lfo_pkg::WAVE_SQUARE:   w = m_phase[15] ? 0 : 255;
            lfo_pkg::WAVE_TRIANGLE: w = m_phase[15] ? 255 - 2 * t : 2 * t;
            default:                w = int'(m_lfsr[7:0]);
        endcase
        am = (w * int'(m_amd)) >> 7;
        // centred on zero, arithmetic shift keeps the sign
        pm = ((w - 128) * int'(m_pmd)) >>> 7;
        res.am = am[7:0];
        res.pm = pm[7:0];
        return res;
    endfunction

    task automatic model_write(input lfo_pkg::reg_write_t w);
        case (w.addr)
            lfo_pkg::REG_CTRL: begin
                if (w.data[0]) begin
                    m_phase = '0;
                end
            end
            lfo_pkg::REG_FREQ: begin
                m_freq = w.data;
            end
            lfo_pkg::REG_DEPTH: begin
                if (w.data[7]) begin
                    m_pmd = w.data[6:0];
                end else begin
                    m_amd = w.data[6:0];
                end
            end
            default: begin
                m_wave = lfo_pkg::lfo_wave_e'(w.data[1:0]);
            end
        endcase
    endtask

    // one write per cycle, driven 2 ns after the edge
    task automatic apply_writes(input int s);
        for (int i = 0; i < step_nwr[s]; i++) begin
            wr_strobe = 1'b1;
            wr        = step_wr[s][i];
            model_write(step_wr[s][i]);
            @(posedge clk);
            #2;
        end
        wr_strobe = 1'b0;
        wr        = '0;
    endtask

    task automatic wait_valid(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            #2;
            cycles++;
        end while (!out_valid && cycles < WAIT_LIMIT);
        if (!out_valid) begin
            $display("no out_valid within %0d cycles in step %s", WAIT_LIMIT, name);
            fail_run("timeout");
        end
    endtask

    task automatic build_table();
        add_step("reset_idle", 3);
        add_step("saw_full_depth", 4);
        add_write(lfo_pkg::REG_WAVE, 8'h00);
        add_write(lfo_pkg::REG_DEPTH, 8'h7f);
        add_write(lfo_pkg::REG_DEPTH, 8'hff);
        add_write(lfo_pkg::REG_FREQ, 8'h9a);
        add_step("saw_fast", 12);
        add_write(lfo_pkg::REG_FREQ, 8'hc7);
        add_step("saw_max_freq", 4);
        add_write(lfo_pkg::REG_FREQ, 8'hff);
        add_step("square_wrap", 8);
        add_write(lfo_pkg::REG_WAVE, 8'h01);
        add_write(lfo_pkg::REG_FREQ, 8'hd8);
        add_step("triangle_wrap", 8);
        add_write(lfo_pkg::REG_WAVE, 8'h02);
        add_step("noise_seq", 6);
        add_write(lfo_pkg::REG_WAVE, 8'h03);
        add_step("noise_after_clear", 4);
        add_write(lfo_pkg::REG_CTRL, 8'h01);
        add_step("phase_restart", 3);
        add_write(lfo_pkg::REG_WAVE, 8'h00);
        add_write(lfo_pkg::REG_FREQ, 8'h80);
        add_write(lfo_pkg::REG_CTRL, 8'h01);
        add_step("pm_depth_only", 3);
        add_write(lfo_pkg::REG_DEPTH, 8'h85);
        add_step("am_depth_only", 3);
        add_write(lfo_pkg::REG_DEPTH, 8'h20);
        add_step("ctrl_bit0_low", 2);
        add_write(lfo_pkg::REG_CTRL, 8'h02);
        // random rows walk through all four waveforms
        for (int i = 0; i < 8; i++) begin
            add_step($sformatf("random_%0d", i), 5);
            add_write(lfo_pkg::REG_WAVE, 8'(i % 4));
            add_write(lfo_pkg::REG_FREQ, 8'($urandom));
            add_write(lfo_pkg::REG_DEPTH, {1'b0, 7'($urandom)});
            add_write(lfo_pkg::REG_DEPTH, {1'b1, 7'($urandom)});
        end
    endtask

    initial begin
        lfo_pkg::lfo_out_t exp_v;
        clk       = 1'b0;
        rst       = 1'b1;
        wr_strobe = 1'b0;
        wr        = '0;
        m_phase   = '0;
        m_lfsr    = lfo_pkg::LFSR_SEED;
        m_freq    = '0;
        m_amd     = '0;
        m_pmd     = '0;
        m_wave    = lfo_pkg::WAVE_SAW;
        num_steps = 0;
        void'($urandom(32'he75f_958c));
        build_table();

        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        compare_out("reset", '0, out);
        compare_valid("reset", 1'b0, out_valid);

        for (int s = 0; s < num_steps; s++) begin
            apply_writes(s);
            for (int n = 0; n < step_nout[s]; n++) begin
                wait_valid(step_name[s]);
                // one tick behind every output strobe
                m_phase = m_phase + phase_inc(m_freq);
                m_lfsr  = lfsr_next(m_lfsr);
                exp_v   = model_out();
                compare_out(step_name[s], exp_v, out);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
